// File: verilog/lc4_pkg.sv
//##################################################
// lc4 shared types: machine word, decoded ops and
// the structs carried between pipeline stages
//##################################################
`default_nettype none

package lc4_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;
   // one-hot, n in bit 2, z in bit 1, p in bit 0
   typedef logic [2:0]  nzp_t;

   typedef enum logic [3:0] {
      OP_NOP,
      OP_BR,
      OP_ADD,
      OP_SUB,
      OP_ADDI,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_LDR,
      OP_STR,
      OP_CONST
   } op_e;

   // insn[15:12]
   typedef enum logic [3:0] {
      OPC_BR    = 4'b0000,
      OPC_ARITH = 4'b0001,
      OPC_LOGIC = 4'b0101,
      OPC_LDR   = 4'b0110,
      OPC_STR   = 4'b0111,
      OPC_CONST = 4'b1001
   } opcode_e;

   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      op_e      op;
      reg_idx_t rs_sel;
      reg_idx_t rt_sel;
      reg_idx_t wsel;
      word_t    rs_data;
      word_t    rt_data;
      logic     regfile_we;
      logic     reads_rs;
      logic     reads_rt;
      word_t    imm;
   } dx_t;

   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      op_e      op;
      word_t    result;
      word_t    store_data;
      reg_idx_t wsel;
      logic     regfile_we;
   } xm_t;

   typedef struct packed {
      logic     we;
      reg_idx_t wsel;
      word_t    data;
   } fwd_t;

   typedef struct packed {
      logic  we;
      word_t addr;
      word_t wdata;
   } dmem_req_t;

   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     regfile_we;
      reg_idx_t wsel;
      word_t    wdata;
      logic     nzp_we;
      nzp_t     nzp;
      logic     mem_we;
      word_t    mem_addr;
      word_t    mem_data;
   } wb_trace_t;

   // condition code of a written value
   function automatic nzp_t nzp_of(input word_t w);
      if (w[15]) begin
         return 3'b100;
      end else if (w == '0) begin
         return 3'b010;
      end
      return 3'b001;
   endfunction

endpackage

`default_nettype wire

// File: verilog/lc4_regfile.sv
//##################################################
// lc4_regfile: 8 x 16-bit, 2 read, 1 write port
//##################################################
`default_nettype none

module lc4_regfile (
   input  logic              gwe,
   input  logic              i_rst_n,
   input  lc4_pkg::reg_idx_t i_rs,
   input  lc4_pkg::reg_idx_t i_rt,
   input  lc4_pkg::fwd_t     i_wr,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data
);
   lc4_pkg::word_t regs [8];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr.we) begin
         regs[i_wr.wsel] <= i_wr.data;
      end
   end

   // write-through: same-cycle write shows on the read port
   assign o_rs_data = (i_wr.we && (i_wr.wsel == i_rs)) ? i_wr.data : regs[i_rs];
   assign o_rt_data = (i_wr.we && (i_wr.wsel == i_rt)) ? i_wr.data : regs[i_rt];

endmodule

`default_nettype wire

// File: verilog/lc4_fetch.sv
//##################################################
// lc4_fetch: pc, next-pc select, f/d register
//##################################################
`default_nettype none

module lc4_fetch #(
   parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
   input  logic           gwe,
   input  logic           i_rst_n,
   input  logic           i_stall,
   input  logic           i_redirect,
   input  lc4_pkg::word_t i_target,
   input  lc4_pkg::word_t i_insn,
   output lc4_pkg::word_t o_pc,
   output lc4_pkg::word_t o_fd_pc,
   output lc4_pkg::word_t o_fd_insn,
   output logic           o_fd_valid
);
   lc4_pkg::word_t pc_q;
   lc4_pkg::word_t next_pc;

   // redirect wins over stall
   assign next_pc = i_redirect ? i_target :
                    i_stall    ? pc_q     : pc_q + 16'd1;
   assign o_pc = pc_q;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q <= RESET_PC;
      end else begin
         pc_q <= next_pc;
      end
   end

   // f/d valid is control, pc and insn are payload
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_fd_valid <= 1'b0;
      end else if (i_redirect) begin
         // younger insn in f is squashed
         o_fd_valid <= 1'b0;
      end else if (!i_stall) begin
         o_fd_valid <= 1'b1;
      end
   end

   always_ff @(posedge gwe) begin
      if (!i_stall) begin
         o_fd_pc   <= pc_q;
         o_fd_insn <= i_insn;
      end
   end

   // load in x and taken branch in x cannot coexist
   a_no_stall_redirect : assert property (@(posedge gwe) disable iff (!i_rst_n)
      !(i_stall && i_redirect));

endmodule

`default_nettype wire

// File: verilog/lc4_decode.sv
//##################################################
// lc4_decode: decoder, load-use stall, d/x register
//##################################################
`default_nettype none

module lc4_decode (
   input  logic              gwe,
   input  logic              i_rst_n,
   input  lc4_pkg::word_t    i_fd_pc,
   input  lc4_pkg::word_t    i_fd_insn,
   input  logic              i_fd_valid,
   input  logic              i_redirect,
   input  lc4_pkg::fwd_t     i_w_fwd,
   output logic              o_stall,
   output lc4_pkg::dx_t      o_dx
);
   lc4_pkg::opcode_e  opcode;
   lc4_pkg::op_e      op;
   lc4_pkg::reg_idx_t rs_sel;
   lc4_pkg::reg_idx_t rt_sel;
   lc4_pkg::word_t    rs_data;
   lc4_pkg::word_t    rt_data;
   lc4_pkg::word_t    imm;
   logic              reads_rs;
   logic              reads_rt;
   logic              writes;
   logic              x_load;
   logic              hazard;
   logic              dx_valid;

   assign opcode = lc4_pkg::opcode_e'(i_fd_insn[15:12]);
   assign rs_sel = i_fd_insn[8:6];
   // str takes its data register from the rd field
   assign rt_sel = (opcode == lc4_pkg::OPC_STR) ? i_fd_insn[11:9] : i_fd_insn[2:0];

   // opcode plus sub-op to op_e, anything else is a nop
   always_comb begin
      op = lc4_pkg::OP_NOP;
      case (opcode)
         lc4_pkg::OPC_BR:    op = lc4_pkg::OP_BR;
         lc4_pkg::OPC_ARITH: begin
            if (i_fd_insn[5]) begin
               op = lc4_pkg::OP_ADDI;
            end else if (i_fd_insn[4:3] == 2'b00) begin
               op = lc4_pkg::OP_ADD;
            end else if (i_fd_insn[4:3] == 2'b10) begin
               op = lc4_pkg::OP_SUB;
            end
         end
         lc4_pkg::OPC_LOGIC: begin
            // and-immediate and not fall through as nop
            case (i_fd_insn[5:3])
               3'b000:  op = lc4_pkg::OP_AND;
               3'b010:  op = lc4_pkg::OP_OR;
               3'b011:  op = lc4_pkg::OP_XOR;
               default: op = lc4_pkg::OP_NOP;
            endcase
         end
         lc4_pkg::OPC_LDR:   op = lc4_pkg::OP_LDR;
         lc4_pkg::OPC_STR:   op = lc4_pkg::OP_STR;
         lc4_pkg::OPC_CONST: op = lc4_pkg::OP_CONST;
         default:            op = lc4_pkg::OP_NOP;
      endcase
   end

   assign reads_rs = op inside {lc4_pkg::OP_ADD, lc4_pkg::OP_SUB, lc4_pkg::OP_ADDI,
                                lc4_pkg::OP_AND, lc4_pkg::OP_OR, lc4_pkg::OP_XOR,
                                lc4_pkg::OP_LDR, lc4_pkg::OP_STR};
   assign reads_rt = op inside {lc4_pkg::OP_ADD, lc4_pkg::OP_SUB, lc4_pkg::OP_AND,
                                lc4_pkg::OP_OR, lc4_pkg::OP_XOR, lc4_pkg::OP_STR};
   // only alu ops, const and ldr write a register
   assign writes = op inside {lc4_pkg::OP_ADD, lc4_pkg::OP_SUB, lc4_pkg::OP_ADDI,
                              lc4_pkg::OP_AND, lc4_pkg::OP_OR, lc4_pkg::OP_XOR,
                              lc4_pkg::OP_LDR, lc4_pkg::OP_CONST};

   // sign-extended immediate by format
   always_comb begin
      case (op)
         lc4_pkg::OP_BR,
         lc4_pkg::OP_CONST: imm = {{7{i_fd_insn[8]}}, i_fd_insn[8:0]};
         lc4_pkg::OP_ADDI:  imm = {{11{i_fd_insn[4]}}, i_fd_insn[4:0]};
         lc4_pkg::OP_LDR,
         lc4_pkg::OP_STR:   imm = {{10{i_fd_insn[5]}}, i_fd_insn[5:0]};
         default:           imm = '0;
      endcase
   end

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs      (rs_sel),
      .i_rt      (rt_sel),
      .i_wr      (i_w_fwd),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   // load in x whose result d needs next cycle
   assign x_load  = o_dx.valid && o_dx.regfile_we && (o_dx.op == lc4_pkg::OP_LDR);
   // branches also wait so the load nzp comes from w
   assign hazard  = (reads_rs && (rs_sel == o_dx.wsel)) ||
                    (reads_rt && (rt_sel == o_dx.wsel)) ||
                    (op == lc4_pkg::OP_BR);
   assign o_stall = i_fd_valid && x_load && hazard;

   // bubble on stall or on a taken branch in x
   assign dx_valid = i_fd_valid && !o_stall && !i_redirect;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_dx <= '0;
      end else begin
         o_dx.valid      <= dx_valid;
         o_dx.pc         <= i_fd_pc;
         o_dx.insn       <= i_fd_insn;
         o_dx.op         <= op;
         o_dx.rs_sel     <= rs_sel;
         o_dx.rt_sel     <= rt_sel;
         o_dx.wsel       <= i_fd_insn[11:9];
         o_dx.rs_data    <= rs_data;
         o_dx.rt_data    <= rt_data;
         o_dx.regfile_we <= writes && dx_valid;
         o_dx.reads_rs   <= reads_rs;
         o_dx.reads_rt   <= reads_rt;
         o_dx.imm        <= imm;
      end
   end

   // str and br encodings never reach x as register writers
   a_no_we_str_br : assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_dx.valid |-> !(o_dx.regfile_we &&
                       (o_dx.insn[15:12] inside {lc4_pkg::OPC_STR, lc4_pkg::OPC_BR})));

endmodule

`default_nettype wire

// File: verilog/lc4_execute.sv
//##################################################
// lc4_execute: bypass, alu, branch resolve, x/m reg
//##################################################
`default_nettype none

module lc4_execute (
   input  logic           gwe,
   input  logic           i_rst_n,
   input  lc4_pkg::dx_t   i_dx,
   input  lc4_pkg::fwd_t  i_m_fwd,
   input  lc4_pkg::fwd_t  i_w_fwd,
   input  lc4_pkg::nzp_t  i_nzp,
   output logic           o_redirect,
   output lc4_pkg::word_t o_target,
   output lc4_pkg::xm_t   o_xm
);
   lc4_pkg::word_t rs_val;
   lc4_pkg::word_t rt_val;
   lc4_pkg::word_t result;
   lc4_pkg::nzp_t  eff_nzp;

   // m before w before the register file value
   function automatic lc4_pkg::word_t bypass(
      input logic              used,
      input lc4_pkg::reg_idx_t sel,
      input lc4_pkg::word_t    rf_data,
      input lc4_pkg::fwd_t     m,
      input lc4_pkg::fwd_t     w
   );
      if (used && m.we && (m.wsel == sel)) begin
         return m.data;
      end else if (used && w.we && (w.wsel == sel)) begin
         return w.data;
      end
      return rf_data;
   endfunction

   assign rs_val = bypass(i_dx.reads_rs, i_dx.rs_sel, i_dx.rs_data, i_m_fwd, i_w_fwd);
   assign rt_val = bypass(i_dx.reads_rt, i_dx.rt_sel, i_dx.rt_data, i_m_fwd, i_w_fwd);

   always_comb begin
      case (i_dx.op)
         lc4_pkg::OP_ADD:   result = rs_val + rt_val;
         lc4_pkg::OP_SUB:   result = rs_val - rt_val;
         lc4_pkg::OP_AND:   result = rs_val & rt_val;
         lc4_pkg::OP_OR:    result = rs_val | rt_val;
         lc4_pkg::OP_XOR:   result = rs_val ^ rt_val;
         // addi and memory address share the adder form
         lc4_pkg::OP_ADDI,
         lc4_pkg::OP_LDR,
         lc4_pkg::OP_STR:   result = rs_val + i_dx.imm;
         lc4_pkg::OP_CONST: result = i_dx.imm;
         default:           result = '0;
      endcase
   end

   // nzp of the youngest older writer, else the committed code
   assign eff_nzp = i_m_fwd.we ? lc4_pkg::nzp_of(i_m_fwd.data) :
                    i_w_fwd.we ? lc4_pkg::nzp_of(i_w_fwd.data) : i_nzp;

   // taken when any requested condition bit matches
   assign o_redirect = i_dx.valid && (i_dx.op == lc4_pkg::OP_BR) &&
                       |(eff_nzp & i_dx.insn[11:9]);
   assign o_target   = i_dx.pc + 16'd1 + i_dx.imm;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_xm <= '0;
      end else begin
         o_xm.valid      <= i_dx.valid;
         o_xm.pc         <= i_dx.pc;
         o_xm.insn       <= i_dx.insn;
         o_xm.op         <= i_dx.op;
         o_xm.result     <= result;
         // forwarded rt is the store data
         o_xm.store_data <= rt_val;
         o_xm.wsel       <= i_dx.wsel;
         o_xm.regfile_we <= i_dx.regfile_we;
      end
   end

   // only a br encoding that writes no register may redirect
   a_redirect_br : assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_redirect |-> ((i_dx.insn[15:12] == lc4_pkg::OPC_BR) && !i_dx.regfile_we));

endmodule

`default_nettype wire

// File: verilog/lc4_mem_wb.sv
//##################################################
// lc4_mem_wb: dmem request, m/w reg, nzp and trace
//##################################################
`default_nettype none

module lc4_mem_wb (
   input  logic               gwe,
   input  logic               i_rst_n,
   input  lc4_pkg::xm_t       i_xm,
   input  lc4_pkg::word_t     i_dmem_rdata,
   output lc4_pkg::dmem_req_t o_dmem_req,
   output lc4_pkg::fwd_t      o_m_fwd,
   output lc4_pkg::fwd_t      o_w_fwd,
   output lc4_pkg::nzp_t      o_nzp,
   output lc4_pkg::wb_trace_t o_trace
);
   logic               is_load;
   logic               is_store;
   lc4_pkg::word_t     wdata;
   lc4_pkg::wb_trace_t mw_d;
   lc4_pkg::wb_trace_t mw_q;
   lc4_pkg::nzp_t      nzp_q;

   assign is_load  = i_xm.valid && (i_xm.op == lc4_pkg::OP_LDR);
   assign is_store = i_xm.valid && (i_xm.op == lc4_pkg::OP_STR);

   // address is the alu result, write lands on the next edge
   assign o_dmem_req = '{we: is_store, addr: i_xm.result, wdata: i_xm.store_data};

   // load data is not ready in time for x, so m skips loads
   assign o_m_fwd = '{we: i_xm.regfile_we && !is_load, wsel: i_xm.wsel, data: i_xm.result};

   assign wdata = is_load ? i_dmem_rdata : i_xm.result;

   always_comb begin
      mw_d.valid      = i_xm.valid;
      mw_d.pc         = i_xm.pc;
      mw_d.insn       = i_xm.insn;
      mw_d.regfile_we = i_xm.regfile_we;
      mw_d.wsel       = i_xm.wsel;
      mw_d.wdata      = wdata;
      // every register write also sets nzp
      mw_d.nzp_we     = i_xm.regfile_we;
      mw_d.nzp        = lc4_pkg::nzp_of(wdata);
      mw_d.mem_we     = is_store;
      mw_d.mem_addr   = (is_load || is_store) ? i_xm.result : '0;
      mw_d.mem_data   = is_store ? i_xm.store_data :
                        is_load  ? i_dmem_rdata    : '0;
   end

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mw_q <= '0;
      end else begin
         mw_q <= mw_d;
      end
   end

   // committed condition code, written as w retires
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         nzp_q <= '0;
      end else if (mw_q.nzp_we) begin
         nzp_q <= mw_q.nzp;
      end
   end

   assign o_w_fwd = '{we: mw_q.regfile_we, wsel: mw_q.wsel, data: mw_q.wdata};
   assign o_nzp   = nzp_q;
   assign o_trace = mw_q;

   // a store request only comes from a str encoding that writes no register
   a_store_insn : assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_dmem_req.we |-> ((i_xm.insn[15:12] == lc4_pkg::OPC_STR) && !i_xm.regfile_we));

endmodule

`default_nettype wire

// File: verilog/lc4_core.sv
//##################################################
// lc4_core: five-stage pipelined lc4 subset core
//##################################################
`default_nettype none

module lc4_core #(
   parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
   input  logic                gwe,
   input  logic                i_rst_n,
   output lc4_pkg::word_t      o_imem_addr,
   input  lc4_pkg::word_t      i_imem_insn,
   output lc4_pkg::dmem_req_t  o_dmem_req,
   input  lc4_pkg::word_t      i_dmem_rdata,
   output lc4_pkg::wb_trace_t  o_trace
);
   // f/d stage
   lc4_pkg::word_t fd_pc;
   lc4_pkg::word_t fd_insn;
   logic           fd_valid;
   // control back to fetch
   logic           stall;
   logic           redirect;
   lc4_pkg::word_t target;
   // stage registers and bypass sources
   lc4_pkg::dx_t   dx;
   lc4_pkg::xm_t   xm;
   lc4_pkg::fwd_t  m_fwd;
   lc4_pkg::fwd_t  w_fwd;
   lc4_pkg::nzp_t  nzp;

   lc4_fetch #(.RESET_PC(RESET_PC)) u_fetch (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_stall    (stall),
      .i_redirect (redirect),
      .i_target   (target),
      .i_insn     (i_imem_insn),
      .o_pc       (o_imem_addr),
      .o_fd_pc    (fd_pc),
      .o_fd_insn  (fd_insn),
      .o_fd_valid (fd_valid)
   );

   lc4_decode u_decode (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_fd_pc    (fd_pc),
      .i_fd_insn  (fd_insn),
      .i_fd_valid (fd_valid),
      .i_redirect (redirect),
      .i_w_fwd    (w_fwd),
      .o_stall    (stall),
      .o_dx       (dx)
   );

   lc4_execute u_execute (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_dx       (dx),
      .i_m_fwd    (m_fwd),
      .i_w_fwd    (w_fwd),
      .i_nzp      (nzp),
      .o_redirect (redirect),
      .o_target   (target),
      .o_xm       (xm)
   );

   lc4_mem_wb u_mem_wb (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_xm         (xm),
      .i_dmem_rdata (i_dmem_rdata),
      .o_dmem_req   (o_dmem_req),
      .o_m_fwd      (m_fwd),
      .o_w_fwd      (w_fwd),
      .o_nzp        (nzp),
      .o_trace      (o_trace)
   );

endmodule

`default_nettype wire

// File: dv/lc4_tb.sv
//##################################################
// lc4_tb: runs the test program on lc4_core and
// checks every retirement seen on the trace port
//##################################################
`default_nettype none

module lc4_tb;

   localparam lc4_pkg::word_t RESET_PC = 16'h8200;
   // longest gap between retirements is a stall plus a flush
   localparam int RETIRE_TIMEOUT = 16;
   localparam int TD_DEPTH = 512;

   logic               gwe;
   logic               i_rst_n;
   lc4_pkg::word_t     imem_addr;
   lc4_pkg::word_t     imem_insn;
   lc4_pkg::dmem_req_t dmem_req;
   lc4_pkg::word_t     dmem_rdata;
   lc4_pkg::wb_trace_t trace;
   // request seen at the last edge, the m cycle of what now retires
   lc4_pkg::dmem_req_t m_req;

   lc4_pkg::word_t imem [65536];
   lc4_pkg::word_t dmem [65536];
   // raw words of the test data file
   lc4_pkg::word_t tdata [TD_DEPTH];
   int             n_prog;
   int             n_data;
   int             n_exp;

   lc4_core #(.RESET_PC(RESET_PC)) UUT (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .o_imem_addr  (imem_addr),
      .i_imem_insn  (imem_insn),
      .o_dmem_req   (dmem_req),
      .i_dmem_rdata (dmem_rdata),
      .o_trace      (trace)
   );

   initial gwe = 1'b0;
   always #4 gwe = ~gwe;

   // both memories answer within the cycle
   assign imem_insn  = imem[imem_addr];
   assign dmem_rdata = dmem[dmem_req.addr];

   // store lands on the edge that ends its m cycle
   always @(posedge gwe) begin
      if (dmem_req.we) begin
         dmem[dmem_req.addr] <= dmem_req.wdata;
      end
      m_req <= dmem_req;
   end

   function automatic lc4_pkg::word_t td(input int i);
      return tdata[i[8:0]];
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input lc4_pkg::word_t got,
                             input lc4_pkg::word_t exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_reg(input string name, input lc4_pkg::reg_idx_t got,
                            input lc4_pkg::reg_idx_t exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_nzp(input string name, input lc4_pkg::nzp_t got,
                            input lc4_pkg::nzp_t exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic load_memories();
      int base;
      $readmemh("dv/lc4_testdata.txt", tdata);
      n_prog = int'(td(0));
      n_data = int'(td(1));
      n_exp  = int'(td(2));
      if (n_exp == 0 || 3 + 2 * (n_prog + n_data) + 9 * n_exp > TD_DEPTH) begin
         fail_run("test data file is missing or its record counts do not fit");
      end
      // fill words equal their address, 8xxx decodes as a nop
      for (int a = 0; a < 65536; a++) begin
         imem[a[15:0]] = a[15:0];
         dmem[a[15:0]] <= a[15:0] ^ 16'h5a5a;
      end
      for (int i = 0; i < n_prog; i++) begin
         imem[td(3 + 2 * i)] = td(4 + 2 * i);
      end
      base = 3 + 2 * n_prog;
      for (int i = 0; i < n_data; i++) begin
         dmem[td(base + 2 * i)] <= td(base + 2 * i + 1);
      end
   endtask

   // one expected retirement, nine words from base
   function automatic lc4_pkg::wb_trace_t record_at(input int base);
      lc4_pkg::wb_trace_t r;
      r            = '0;
      r.valid      = 1'b1;
      r.pc         = td(base);
      r.insn       = td(base + 1);
      r.regfile_we = 1'(td(base + 2));
      r.wsel       = lc4_pkg::reg_idx_t'(td(base + 3));
      r.wdata      = td(base + 4);
      // every register write also writes nzp
      r.nzp_we     = 1'(td(base + 2));
      r.nzp        = lc4_pkg::nzp_t'(td(base + 5));
      r.mem_we     = 1'(td(base + 6));
      r.mem_addr   = td(base + 7);
      r.mem_data   = td(base + 8);
      return r;
   endfunction

   // sample at the falling edge, trace is settled by then
   task automatic wait_retire(input int idx, input lc4_pkg::word_t pc);
      int cycles;
      cycles = 0;
      @(negedge gwe);
      while (!trace.valid) begin
         // nothing reaches data memory before the first retirement
         if (idx == 0) begin
            check_bit("o_dmem_req.we", dmem_req.we, 1'b0);
         end
         cycles++;
         if (cycles > RETIRE_TIMEOUT) begin
            fail_run($sformatf("expected record %0d with pc %h never retired within %0d cycles",
                               idx, pc, RETIRE_TIMEOUT));
         end
         @(negedge gwe);
      end
   endtask

   task automatic compare_record(input lc4_pkg::wb_trace_t exp);
      check_word("o_trace.pc", trace.pc, exp.pc);
      check_word("o_trace.insn", trace.insn, exp.insn);
      check_bit("o_trace.regfile_we", trace.regfile_we, exp.regfile_we);
      check_bit("o_trace.nzp_we", trace.nzp_we, exp.nzp_we);
      // destination fields only mean something for a writer
      if (exp.regfile_we) begin
         check_reg("o_trace.wsel", trace.wsel, exp.wsel);
         check_word("o_trace.wdata", trace.wdata, exp.wdata);
         check_nzp("o_trace.nzp", trace.nzp, exp.nzp);
      end
      check_bit("o_trace.mem_we", trace.mem_we, exp.mem_we);
      // the request went out one cycle before this retirement
      check_bit("o_dmem_req.we", m_req.we, exp.mem_we);
      if (exp.mem_we) begin
         check_word("o_trace.mem_addr", trace.mem_addr, exp.mem_addr);
         check_word("o_trace.mem_data", trace.mem_data, exp.mem_data);
         check_word("o_dmem_req.addr", m_req.addr, exp.mem_addr);
         check_word("o_dmem_req.wdata", m_req.wdata, exp.mem_data);
      end
   endtask

   initial begin
      lc4_pkg::wb_trace_t expected;
      int                 base;
      i_rst_n = 1'b0;
      load_memories();
      // reset spans four rising edges, released on the last one
      for (int c = 0; c < 4; c++) begin
         @(posedge gwe);
         if (c == 3) begin
            i_rst_n <= 1'b1;
         end
         @(negedge gwe);
         check_bit("o_trace.valid", trace.valid, 1'b0);
         check_bit("o_dmem_req.we", dmem_req.we, 1'b0);
         check_word("o_imem_addr", imem_addr, RESET_PC);
      end
      base = 3 + 2 * (n_prog + n_data);
      for (int k = 0; k < n_exp; k++) begin
         expected = record_at(base + 9 * k);
         wait_retire(k, expected.pc);
         compare_record(expected);
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
verilog/lc4_pkg.sv
verilog/lc4_regfile.sv
verilog/lc4_fetch.sv
verilog/lc4_decode.sv
verilog/lc4_execute.sv
verilog/lc4_mem_wb.sv
verilog/lc4_core.sv
dv/lc4_tb.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat all.f))

.PHONY: run clean

run: obj_dir/Vlc4_tb
	./obj_dir/Vlc4_tb

obj_dir/Vlc4_tb: all.f $(SRCS)
	verilator --binary --timing --assert --top-module lc4_tb -f all.f

clean:
	rm -rf obj_dir

// File: dv/lc4_testdata.txt
// first line holds the program, data and expected record counts in hex
// then address and instruction pairs, address and data pairs, then one expected record per line
// expected columns are pc insn rf_we wsel wdata nzp mem_we mem_addr mem_data
0018 0002 0016
8200 9205  8201 95FD  8202 1642  8203 18FE
8204 1B11  8205 5D43  8206 5F91  8207 53DA
8208 9010  8209 7E02  820A 6402  820B 1682
820C 0C01  820D 9801  820E 0202  820F 9A07
8210 9C07  8211 6204  8212 0801  8213 9E00
8214 6A05  8215 0A01  8216 7606  8217 0FFF
0014 8000  0015 0000
8200 9205 1 1 0005 1 0 0000 0000
8201 95FD 1 2 FFFD 4 0 0000 0000
8202 1642 1 3 0002 1 0 0000 0000
8203 18FE 1 4 0000 2 0 0000 0000
8204 1B11 1 5 FFFB 4 0 0000 0000
8205 5D43 1 6 0002 1 0 0000 0000
8206 5F91 1 7 0007 1 0 0000 0000
8207 53DA 1 1 FFFA 4 0 0000 0000
8208 9010 1 0 0010 1 0 0000 0000
8209 7E02 0 0 0000 0 1 0012 0007
820A 6402 1 2 0007 1 0 0000 0000
820B 1682 1 3 000E 1 0 0000 0000
820C 0C01 0 0 0000 0 0 0000 0000
820D 9801 1 4 0001 1 0 0000 0000
820E 0202 0 0 0000 0 0 0000 0000
8211 6204 1 1 8000 4 0 0000 0000
8212 0801 0 0 0000 0 0 0000 0000
8214 6A05 1 5 0000 2 0 0000 0000
8215 0A01 0 0 0000 0 0 0000 0000
8216 7606 0 0 0000 0 1 0016 000E
8217 0FFF 0 0 0000 0 0 0000 0000
8217 0FFF 0 0 0000 0 0 0000 0000
